//--- flist.f
hdl/simmem_pkg.sv
hdl/word_ram.sv
hdl/port_arbiter.sv
hdl/burst_port.sv
hdl/axi_sim_mem_top.sv
verif/sim_mem_assertions.sv
verif/tb_sim_mem.sv

//--- hdl/axi_sim_mem_top.sv
// Shared 256-word memory behind NUM_PORTS burst ports; word index wraps at the top of memory
`timescale 1ns/1ps

module axi_sim_mem_top (
  input  logic                                                     clk_i,
  input  logic                                                     arst_n_i,
  input  logic [simmem_pkg::NUM_PORTS-1:0]                         aw_valid_i,
  input  logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::ADDR_W-1:0] aw_addr_i,
  input  logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::LEN_W-1:0]  aw_len_i,
  input  logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::BURST_W-1:0] aw_burst_i,
  input  logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::ID_W-1:0]   aw_id_i,
  output logic [simmem_pkg::NUM_PORTS-1:0]                         aw_ready_o,
  input  logic [simmem_pkg::NUM_PORTS-1:0]                         w_valid_i,
  input  logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::DATA_W-1:0] w_data_i,
  input  logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::STRB_W-1:0] w_strb_i,
  input  logic [simmem_pkg::NUM_PORTS-1:0]                         w_last_i,
  output logic [simmem_pkg::NUM_PORTS-1:0]                         w_ready_o,
  output logic [simmem_pkg::NUM_PORTS-1:0]                         b_valid_o,
  output logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::ID_W-1:0]   b_id_o,
  output logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::RESP_W-1:0] b_resp_o,
  input  logic [simmem_pkg::NUM_PORTS-1:0]                         b_ready_i,
  input  logic [simmem_pkg::NUM_PORTS-1:0]                         ar_valid_i,
  input  logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::ADDR_W-1:0] ar_addr_i,
  input  logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::LEN_W-1:0]  ar_len_i,
  input  logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::BURST_W-1:0] ar_burst_i,
  input  logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::ID_W-1:0]   ar_id_i,
  output logic [simmem_pkg::NUM_PORTS-1:0]                         ar_ready_o,
  output logic [simmem_pkg::NUM_PORTS-1:0]                         r_valid_o,
  output logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::DATA_W-1:0] r_data_o,
  output logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::ID_W-1:0]   r_id_o,
  output logic [simmem_pkg::NUM_PORTS-1:0]                         r_last_o,
  input  logic [simmem_pkg::NUM_PORTS-1:0]                         r_ready_i,
  output logic [simmem_pkg::NUM_PORTS-1:0]                         mon_w_valid_o,
  output logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::WORD_IDX_W-1:0] mon_w_addr_o,
  output logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::DATA_W-1:0] mon_w_data_o,
  output logic [simmem_pkg::NUM_PORTS-1:0]                         mon_w_last_o,
  output logic [simmem_pkg::NUM_PORTS-1:0]                         mon_r_valid_o,
  output logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::WORD_IDX_W-1:0] mon_r_addr_o,
  output logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::DATA_W-1:0] mon_r_data_o,
  output logic [simmem_pkg::NUM_PORTS-1:0]                         mon_r_last_o
);

  logic [simmem_pkg::NUM_PORTS-1:0]                             mem_req, mem_we, mem_gnt;
  logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::WORD_IDX_W-1:0] mem_idx;
  logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::DATA_W-1:0]     mem_wdata;
  logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::STRB_W-1:0]     mem_strb;
  logic                                                         ram_en, ram_we;
  logic [simmem_pkg::WORD_IDX_W-1:0]                            ram_idx;
  logic [simmem_pkg::DATA_W-1:0]                                ram_wdata, ram_rdata;
  logic [simmem_pkg::STRB_W-1:0]                                ram_be;

  for (genvar p = 0; p < simmem_pkg::NUM_PORTS; p++) begin : g_port
    burst_port u_burst_port (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .aw_valid_i    (aw_valid_i[p]),
      .aw_addr_i     (aw_addr_i[p]),
      .aw_len_i      (aw_len_i[p]),
      .aw_burst_i    (aw_burst_i[p]),
      .aw_id_i       (aw_id_i[p]),
      .aw_ready_o    (aw_ready_o[p]),
      .w_valid_i     (w_valid_i[p]),
      .w_data_i      (w_data_i[p]),
      .w_strb_i      (w_strb_i[p]),
      .w_last_i      (w_last_i[p]),
      .w_ready_o     (w_ready_o[p]),
      .b_valid_o     (b_valid_o[p]),
      .b_id_o        (b_id_o[p]),
      .b_resp_o      (b_resp_o[p]),
      .b_ready_i     (b_ready_i[p]),
      .ar_valid_i    (ar_valid_i[p]),
      .ar_addr_i     (ar_addr_i[p]),
      .ar_len_i      (ar_len_i[p]),
      .ar_burst_i    (ar_burst_i[p]),
      .ar_id_i       (ar_id_i[p]),
      .ar_ready_o    (ar_ready_o[p]),
      .r_valid_o     (r_valid_o[p]),
      .r_data_o      (r_data_o[p]),
      .r_id_o        (r_id_o[p]),
      .r_last_o      (r_last_o[p]),
      .r_ready_i     (r_ready_i[p]),
      .mon_w_valid_o (mon_w_valid_o[p]),
      .mon_w_addr_o  (mon_w_addr_o[p]),
      .mon_w_data_o  (mon_w_data_o[p]),
      .mon_w_last_o  (mon_w_last_o[p]),
      .mon_r_valid_o (mon_r_valid_o[p]),
      .mon_r_addr_o  (mon_r_addr_o[p]),
      .mon_r_data_o  (mon_r_data_o[p]),
      .mon_r_last_o  (mon_r_last_o[p]),
      .mem_req_o     (mem_req[p]),
      .mem_we_o      (mem_we[p]),
      .mem_idx_o     (mem_idx[p]),
      .mem_wdata_o   (mem_wdata[p]),
      .mem_strb_o    (mem_strb[p]),
      .mem_gnt_i     (mem_gnt[p]),
      .ram_rdata_i   (ram_rdata)
    );
  end

  port_arbiter u_port_arbiter (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (mem_req),
    .we_i        (mem_we),
    .idx_i       (mem_idx),
    .wdata_i     (mem_wdata),
    .strb_i      (mem_strb),
    .gnt_o       (mem_gnt),
    .ram_en_o    (ram_en),
    .ram_we_o    (ram_we),
    .ram_idx_o   (ram_idx),
    .ram_wdata_o (ram_wdata),
    .ram_be_o    (ram_be)
  );

  // Read data fans out to every port, the granted one captures it
  word_ram u_word_ram (
    .clk_i   (clk_i),
    .en_i    (ram_en),
    .we_i    (ram_we),
    .idx_i   (ram_idx),
    .wdata_i (ram_wdata),
    .be_i    (ram_be),
    .rdata_o (ram_rdata)
  );

endmodule

//--- hdl/burst_port.sv
// One burst port: a single open write and read burst each, writes win over reads inside the port
`timescale 1ns/1ps

module burst_port (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  // AW
  input  logic                                aw_valid_i,
  input  logic [simmem_pkg::ADDR_W-1:0]       aw_addr_i,
  input  logic [simmem_pkg::LEN_W-1:0]        aw_len_i,
  input  logic [simmem_pkg::BURST_W-1:0]      aw_burst_i,
  input  logic [simmem_pkg::ID_W-1:0]         aw_id_i,
  output logic                                aw_ready_o,
  // W
  input  logic                                w_valid_i,
  input  logic [simmem_pkg::DATA_W-1:0]       w_data_i,
  input  logic [simmem_pkg::STRB_W-1:0]       w_strb_i,
  input  logic                                w_last_i,
  output logic                                w_ready_o,
  // B
  output logic                                b_valid_o,
  output logic [simmem_pkg::ID_W-1:0]         b_id_o,
  output logic [simmem_pkg::RESP_W-1:0]       b_resp_o,
  input  logic                                b_ready_i,
  // AR
  input  logic                                ar_valid_i,
  input  logic [simmem_pkg::ADDR_W-1:0]       ar_addr_i,
  input  logic [simmem_pkg::LEN_W-1:0]        ar_len_i,
  input  logic [simmem_pkg::BURST_W-1:0]      ar_burst_i,
  input  logic [simmem_pkg::ID_W-1:0]         ar_id_i,
  output logic                                ar_ready_o,
  // R
  output logic                                r_valid_o,
  output logic [simmem_pkg::DATA_W-1:0]       r_data_o,
  output logic [simmem_pkg::ID_W-1:0]         r_id_o,
  output logic                                r_last_o,
  input  logic                                r_ready_i,
  // Monitors
  output logic                                mon_w_valid_o,
  output logic [simmem_pkg::WORD_IDX_W-1:0]   mon_w_addr_o,
  output logic [simmem_pkg::DATA_W-1:0]       mon_w_data_o,
  output logic                                mon_w_last_o,
  output logic                                mon_r_valid_o,
  output logic [simmem_pkg::WORD_IDX_W-1:0]   mon_r_addr_o,
  output logic [simmem_pkg::DATA_W-1:0]       mon_r_data_o,
  output logic                                mon_r_last_o,
  // Memory request path
  output logic                                mem_req_o,
  output logic                                mem_we_o,
  output logic [simmem_pkg::WORD_IDX_W-1:0]   mem_idx_o,
  output logic [simmem_pkg::DATA_W-1:0]       mem_wdata_o,
  output logic [simmem_pkg::STRB_W-1:0]       mem_strb_o,
  input  logic                                mem_gnt_i,
  input  logic [simmem_pkg::DATA_W-1:0]       ram_rdata_i
);

  logic                                wr_open_q, wr_fixed_q, wr_err_q;
  logic [simmem_pkg::WORD_IDX_W-1:0]   wr_idx_q;
  logic [simmem_pkg::LEN_W-1:0]        wr_cnt_q, wr_len_q;
  logic [simmem_pkg::ID_W-1:0]         wr_id_q;
  logic                                b_valid_q;
  logic                                rd_open_q, rd_fixed_q;
  logic [simmem_pkg::WORD_IDX_W-1:0]   rd_idx_q;
  logic [simmem_pkg::LEN_W-1:0]        rd_cnt_q, rd_len_q;
  logic [simmem_pkg::ID_W-1:0]         rd_id_q;
  logic                                r_valid_q, r_fresh_q;
  logic [simmem_pkg::DATA_W-1:0]       r_data_q;
  logic wr_req, rd_req, aw_fire, w_fire, ar_fire, r_fire, w_last_exp, w_mismatch;

  assign aw_ready_o = !wr_open_q && !b_valid_q;
  assign ar_ready_o = !rd_open_q;
  assign aw_fire    = aw_valid_i && aw_ready_o;
  assign ar_fire    = ar_valid_i && ar_ready_o;

  // One request per beat, a read only when the R register is free
  assign wr_req     = wr_open_q && w_valid_i;
  assign rd_req     = rd_open_q && !r_valid_q && !wr_req;
  assign mem_req_o  = wr_req || rd_req;
  assign mem_we_o   = wr_req;
  assign mem_idx_o  = wr_req ? wr_idx_q : rd_idx_q;
  assign mem_wdata_o = w_data_i;
  assign mem_strb_o = wr_req ? w_strb_i : '0;

  // The W beat completes with its grant
  assign w_ready_o  = wr_req && mem_gnt_i;
  assign w_fire     = w_ready_o;
  assign w_last_exp = (wr_cnt_q == wr_len_q);
  assign w_mismatch = (w_last_i != w_last_exp);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_open_q  <= 1'b0;
      wr_fixed_q <= 1'b0;
      wr_err_q   <= 1'b0;
      wr_idx_q   <= '0;
      wr_cnt_q   <= '0;
      wr_len_q   <= '0;
      wr_id_q    <= '0;
      b_valid_q  <= 1'b0;
      b_id_o     <= '0;
      b_resp_o   <= simmem_pkg::RESP_OKAY;
    end else begin
      if (aw_fire) begin
        wr_open_q  <= 1'b1;
        wr_fixed_q <= (aw_burst_i == simmem_pkg::BURST_FIXED);
        wr_err_q   <= 1'b0;
        wr_idx_q   <= aw_addr_i[simmem_pkg::WORD_IDX_W+1:2];
        wr_cnt_q   <= '0;
        wr_len_q   <= aw_len_i;
        wr_id_q    <= aw_id_i;
      end else if (w_fire) begin
        // Burst length decides the end, the last flag only feeds the error
        if (w_last_exp) begin
          wr_open_q <= 1'b0;
          b_valid_q <= 1'b1;
          b_id_o    <= wr_id_q;
          b_resp_o  <= (wr_err_q || w_mismatch) ? simmem_pkg::RESP_SLVERR
                                                : simmem_pkg::RESP_OKAY;
        end else begin
          wr_err_q <= wr_err_q || w_mismatch;
          wr_cnt_q <= wr_cnt_q + 1'b1;
          wr_idx_q <= wr_idx_q + {7'd0, !wr_fixed_q};
        end
      end
      if (b_valid_q && b_ready_i) begin
        b_valid_q <= 1'b0;
      end
    end
  end

  assign b_valid_o = b_valid_q;

  // Read data is live on ram_rdata_i in the first R cycle, held afterwards
  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_fresh_q ? ram_rdata_i : r_data_q;
  assign r_id_o    = rd_id_q;
  assign r_last_o  = (rd_cnt_q == rd_len_q);
  assign r_fire    = r_valid_q && r_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_open_q  <= 1'b0;
      rd_fixed_q <= 1'b0;
      rd_idx_q   <= '0;
      rd_cnt_q   <= '0;
      rd_len_q   <= '0;
      rd_id_q    <= '0;
      r_valid_q  <= 1'b0;
      r_fresh_q  <= 1'b0;
    end else begin
      r_fresh_q <= rd_req && mem_gnt_i;
      if (ar_fire) begin
        rd_open_q  <= 1'b1;
        rd_fixed_q <= (ar_burst_i == simmem_pkg::BURST_FIXED);
        rd_idx_q   <= ar_addr_i[simmem_pkg::WORD_IDX_W+1:2];
        rd_cnt_q   <= '0;
        rd_len_q   <= ar_len_i;
        rd_id_q    <= ar_id_i;
      end
      if (rd_req && mem_gnt_i) begin
        r_valid_q <= 1'b1;
      end else if (r_fire) begin
        r_valid_q <= 1'b0;
        if (r_last_o) begin
          rd_open_q <= 1'b0;
        end else begin
          rd_cnt_q <= rd_cnt_q + 1'b1;
          rd_idx_q <= rd_idx_q + {7'd0, !rd_fixed_q};
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (r_fresh_q) begin
      r_data_q <= ram_rdata_i;
    end
  end

  // Monitors trail each transfer by one cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mon_w_valid_o <= 1'b0;
      mon_r_valid_o <= 1'b0;
    end else begin
      mon_w_valid_o <= w_fire;
      mon_r_valid_o <= r_fire;
    end
  end

  always_ff @(posedge clk_i) begin
    mon_w_addr_o <= wr_idx_q;
    mon_w_data_o <= w_data_i;
    mon_w_last_o <= w_last_exp;
    mon_r_addr_o <= rd_idx_q;
    mon_r_data_o <= r_data_o;
    mon_r_last_o <= r_last_o;
  end

endmodule

//--- hdl/port_arbiter.sv
// Round-robin arbiter, one grant per cycle, grant is combinational on the requests
`timescale 1ns/1ps

module port_arbiter (
  input  logic                                                     clk_i,
  input  logic                                                     arst_n_i,
  input  logic [simmem_pkg::NUM_PORTS-1:0]                         req_i,
  input  logic [simmem_pkg::NUM_PORTS-1:0]                         we_i,
  input  logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::WORD_IDX_W-1:0] idx_i,
  input  logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::DATA_W-1:0] wdata_i,
  input  logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::STRB_W-1:0] strb_i,
  output logic [simmem_pkg::NUM_PORTS-1:0]                         gnt_o,
  output logic                                                     ram_en_o,
  output logic                                                     ram_we_o,
  output logic [simmem_pkg::WORD_IDX_W-1:0]                        ram_idx_o,
  output logic [simmem_pkg::DATA_W-1:0]                            ram_wdata_o,
  output logic [simmem_pkg::STRB_W-1:0]                            ram_be_o
);

  // Port with the highest priority in the current cycle
  logic [simmem_pkg::PORT_IDX_W-1:0] ptr_q;
  logic [simmem_pkg::PORT_IDX_W-1:0] sel;
  logic [simmem_pkg::PORT_IDX_W-1:0] ptr_nxt;
  logic                              found;

  always_comb begin
    int cand;
    int nxt;
    found = 1'b0;
    sel   = ptr_q;
    // Search starts at the pointer and wraps once around
    for (int k = 0; k < simmem_pkg::NUM_PORTS; k++) begin
      cand = (int'(ptr_q) + k) % simmem_pkg::NUM_PORTS;
      if (!found && req_i[cand]) begin
        found = 1'b1;
        sel   = cand[simmem_pkg::PORT_IDX_W-1:0];
      end
    end
    nxt     = (int'(sel) + 1) % simmem_pkg::NUM_PORTS;
    ptr_nxt = nxt[simmem_pkg::PORT_IDX_W-1:0];
  end

  always_comb begin
    gnt_o = '0;
    if (found) begin
      gnt_o[sel] = 1'b1;
    end
  end

  // Fields of the winning port go straight to the RAM
  assign ram_en_o    = found;
  assign ram_we_o    = we_i[sel];
  assign ram_idx_o   = idx_i[sel];
  assign ram_wdata_o = wdata_i[sel];
  assign ram_be_o    = strb_i[sel];

  // Pointer moves past the winner, holds when idle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q <= '0;
    end else if (found) begin
      ptr_q <= ptr_nxt;
    end
  end

endmodule

//--- hdl/simmem_pkg.sv
// All sizes and response codes of the shared memory; WRAP bursts decode as INCR, only full-width beats
package simmem_pkg;

  // Port count and derived port index width
  localparam int unsigned NUM_PORTS  = 2;
  localparam int unsigned PORT_IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

  // Byte address, only bits [WORD_IDX_W+1:2] select a word
  localparam int unsigned ADDR_W     = 10;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned STRB_W     = DATA_W / 8;
  localparam int unsigned ID_W       = 4;

  // Burst length field holds beats minus one
  localparam int unsigned LEN_W      = 8;
  localparam int unsigned BURST_W    = 2;

  // Memory geometry
  localparam int unsigned WORD_IDX_W = 8;
  localparam int unsigned MEM_WORDS  = 256;

  // FIXED burst code, every other code runs as INCR
  localparam logic [BURST_W-1:0] BURST_FIXED = 2'b00;

  // B response codes
  localparam int unsigned RESP_W = 2;
  localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
  localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

endpackage

//--- hdl/word_ram.sv
// Single-port RAM without reset; unwritten words read as undefined, rdata only updates on reads
`timescale 1ns/1ps

module word_ram (
  input  logic                                clk_i,
  input  logic                                en_i,
  input  logic                                we_i,
  input  logic [simmem_pkg::WORD_IDX_W-1:0]   idx_i,
  input  logic [simmem_pkg::DATA_W-1:0]       wdata_i,
  input  logic [simmem_pkg::STRB_W-1:0]       be_i,
  output logic [simmem_pkg::DATA_W-1:0]       rdata_o
);

  logic [simmem_pkg::DATA_W-1:0] mem_q [simmem_pkg::MEM_WORDS];

  // Byte-merged write port
  always_ff @(posedge clk_i) begin
    if (en_i && we_i) begin
      for (int b = 0; b < simmem_pkg::STRB_W; b++) begin
        if (be_i[b]) begin
          mem_q[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Read word stays on rdata_o until the next read
  always_ff @(posedge clk_i) begin
    if (en_i && !we_i) begin
      rdata_o <= mem_q[idx_i];
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the fail message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_sim_mem \
  -f flist.f \
  -Mdir obj_dir

if ! ./obj_dir/Vtb_sim_mem > sim.log 2>&1; then
  cat sim.log
  echo "Simulation exited with an error status"
  exit 1
fi
cat sim.log

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
exit 0

//--- verif/sim_mem_assertions.sv
// Handshake checks bound into the top level, all of them idle while reset is asserted
`timescale 1ns/1ps

module sim_mem_assertions (
  input logic                                                     clk_i,
  input logic                                                     arst_n_i,
  input logic [simmem_pkg::NUM_PORTS-1:0]                         aw_ready_o, w_valid_i, w_ready_o,
  input logic [simmem_pkg::NUM_PORTS-1:0]                         b_valid_o, b_ready_i,
  input logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::ID_W-1:0]   b_id_o, r_id_o,
  input logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::RESP_W-1:0] b_resp_o,
  input logic [simmem_pkg::NUM_PORTS-1:0]                         r_valid_o, r_last_o, r_ready_i,
  input logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::DATA_W-1:0] r_data_o,
  input logic [simmem_pkg::NUM_PORTS-1:0]                         mon_w_valid_o
);

  for (genvar p = 0; p < simmem_pkg::NUM_PORTS; p++) begin : g_port
    // R beat holds until the master takes it
    a_r_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      r_valid_o[p] && !r_ready_i[p] |=> r_valid_o[p] && $stable(r_data_o[p])
        && $stable(r_id_o[p]) && $stable(r_last_o[p]))
      else $error("Port %0d R channel changed before its transfer", p);

    a_b_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      b_valid_o[p] && !b_ready_i[p] |=> b_valid_o[p] && $stable(b_id_o[p])
        && $stable(b_resp_o[p]))
      else $error("Port %0d B channel changed before its transfer", p);

    // Write monitor trails the W transfer by exactly one cycle
    a_mon_w : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      mon_w_valid_o[p] |-> $past(w_valid_i[p] && w_ready_o[p]))
      else $error("Port %0d write monitor pulsed without a W transfer", p);

    a_aw_block : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      b_valid_o[p] |-> !aw_ready_o[p])
      else $error("Port %0d accepts AW while a B response is pending", p);
  end

endmodule

bind axi_sim_mem_top sim_mem_assertions u_sim_mem_assertions (.*);

//--- verif/tb_sim_mem.sv
// Tests both ports with the same LFSR stream; every word is fully written before it is read
`timescale 1ns/1ps

module tb_sim_mem;

  // Upper bound of data beats over all tests and ports, sizes the watchdog
  localparam int unsigned MAX_BEATS = 280;

  logic clk_i;
  logic arst_n_i;
  logic [simmem_pkg::NUM_PORTS-1:0]                             aw_valid_i, w_valid_i, w_last_i;
  logic [simmem_pkg::NUM_PORTS-1:0]                             ar_valid_i, b_ready_i, r_ready_i;
  logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::ADDR_W-1:0]     aw_addr_i, ar_addr_i;
  logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::LEN_W-1:0]      aw_len_i, ar_len_i;
  logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::BURST_W-1:0]    aw_burst_i, ar_burst_i;
  logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::ID_W-1:0]       aw_id_i, ar_id_i, b_id_o, r_id_o;
  logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::DATA_W-1:0]     w_data_i, r_data_o;
  logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::DATA_W-1:0]     mon_w_data_o, mon_r_data_o;
  logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::STRB_W-1:0]     w_strb_i;
  logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::RESP_W-1:0]     b_resp_o;
  logic [simmem_pkg::NUM_PORTS-1:0][simmem_pkg::WORD_IDX_W-1:0] mon_w_addr_o, mon_r_addr_o;
  logic [simmem_pkg::NUM_PORTS-1:0]                             aw_ready_o, w_ready_o, ar_ready_o;
  logic [simmem_pkg::NUM_PORTS-1:0]                             b_valid_o, r_valid_o, r_last_o;
  logic [simmem_pkg::NUM_PORTS-1:0]                             mon_w_valid_o, mon_w_last_o;
  logic [simmem_pkg::NUM_PORTS-1:0]                             mon_r_valid_o, mon_r_last_o;

  // Shadow memory and expected beats, kinds are R, B, write monitor, read monitor
  logic [simmem_pkg::DATA_W-1:0] shadow [simmem_pkg::MEM_WORDS];
  logic [63:0] exp_q [4][simmem_pkg::NUM_PORTS][$];
  string       kind_names [4] = '{"R beat", "B response", "write monitor", "read monitor"};
  string       test_name;
  logic [31:0] lfsr_q = 32'had3227fe;
  bit          bp_en;
  int          value_errors;
  int          proto_errors;
  int          r_beats;
  int          mon_r_pulses;

  axi_sim_mem_top u_axi_sim_mem_top (.*);

  always #2 clk_i = (clk_i === 1'b0);

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic int rand_len();
    return 1 + int'(take_bits(3));
  endfunction

  // Reference rules: byte merge by strobe, word index per beat, B response
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[8*i +: 8] = data[8*i +: 8];
    end
    return res;
  endfunction

  function automatic logic [7:0] beat_index(input logic [7:0] start, input int beat, input bit fixed);
    return fixed ? start : start + 8'(beat);
  endfunction

  function automatic logic [1:0] expected_resp(input bit mismatch);
    return mismatch ? simmem_pkg::RESP_SLVERR : simmem_pkg::RESP_OKAY;
  endfunction

  task automatic check_beat(input int kind, input int p, input logic [63:0] seen);
    logic [63:0] want;
    assert (exp_q[kind][p].size() != 0) else begin
      proto_errors++;
      $display("Unexpected %s on port %0d in test %s", kind_names[kind], p, test_name);
    end
    if (exp_q[kind][p].size() != 0) begin
      want = exp_q[kind][p].pop_front();
      assert (seen === want) else begin
        value_errors++;
        $display("[FAIL] %s: %s on port %0d expected %h actual %h",
                 test_name, kind_names[kind], p, want, seen);
      end
    end
  endtask

  // bad_last 1 raises w_last on the first beat, 2 never raises it
  task automatic write_burst(input int p, input logic [7:0] base, input int beats, input bit fixed,
                             input logic [3:0] id, input bit rand_strb, input int bad_last);
    logic [31:0] data;
    logic [3:0]  strb;
    logic [7:0]  idx;
    logic        last;
    bit          mismatch;
    mismatch = 1'b0;
    @(posedge clk_i);
    #1;
    aw_valid_i[p] = 1'b1;
    aw_addr_i[p]  = {base, 2'b00};
    aw_len_i[p]   = 8'(beats - 1);
    aw_burst_i[p] = fixed ? simmem_pkg::BURST_FIXED : 2'b01;
    aw_id_i[p]    = id;
    do @(posedge clk_i); while (!aw_ready_o[p]);
    #1;
    aw_valid_i[p] = 1'b0;
    for (int b = 0; b < beats; b++) begin
      data = take_bits(32);
      strb = rand_strb ? 4'(take_bits(4)) : 4'hf;
      last = (b == beats - 1);
      if (bad_last == 1) last = (b == 0);
      if (bad_last == 2) last = 1'b0;
      mismatch = mismatch || (last != (b == beats - 1));
      idx = beat_index(base, b, fixed);
      shadow[idx] = merge_bytes(shadow[idx], data, strb);
      exp_q[2][p].push_back(64'({idx, data, b == beats - 1}));
      w_valid_i[p] = 1'b1;
      w_data_i[p]  = data;
      w_strb_i[p]  = strb;
      w_last_i[p]  = last;
      do @(posedge clk_i); while (!w_ready_o[p]);
      #1;
    end
    w_valid_i[p] = 1'b0;
    exp_q[1][p].push_back(64'({id, expected_resp(mismatch)}));
    do @(posedge clk_i); while (!(b_valid_o[p] && b_ready_i[p]));
  endtask

  task automatic read_burst(input int p, input logic [7:0] base, input int beats, input bit fixed,
                            input logic [3:0] id);
    logic [7:0] idx;
    for (int b = 0; b < beats; b++) begin
      idx = beat_index(base, b, fixed);
      exp_q[0][p].push_back(64'({id, b == beats - 1, shadow[idx]}));
      exp_q[3][p].push_back(64'({idx, shadow[idx], b == beats - 1}));
    end
    @(posedge clk_i);
    #1;
    ar_valid_i[p] = 1'b1;
    ar_addr_i[p]  = {base, 2'b00};
    ar_len_i[p]   = 8'(beats - 1);
    ar_burst_i[p] = fixed ? simmem_pkg::BURST_FIXED : 2'b01;
    ar_id_i[p]    = id;
    do @(posedge clk_i); while (!ar_ready_o[p]);
    #1;
    ar_valid_i[p] = 1'b0;
    do @(posedge clk_i); while (!(r_valid_o[p] && r_ready_i[p] && r_last_o[p]));
  endtask

  // Full words first, then random strobes over them, then one INCR read
  task automatic incr_case(input int p, input logic [7:0] base);
    int beats;
    beats = rand_len();
    write_burst(p, base, beats, 1'b0, 4'(take_bits(4)), 1'b0, 0);
    write_burst(p, base, beats, 1'b0, 4'(take_bits(4)), 1'b1, 0);
    read_burst(p, base, beats, 1'b0, 4'(take_bits(4)));
  endtask

  task automatic fixed_case(input int p, input logic [7:0] base);
    write_burst(p, base, rand_len(), 1'b1, 4'(take_bits(4)), 1'b1, 0);
    read_burst(p, base, rand_len(), 1'b1, 4'(take_bits(4)));
  endtask

  task automatic last_case(input int p, input logic [7:0] base, input int bad_last);
    write_burst(p, base, 4, 1'b0, 4'h9, 1'b0, bad_last);
    read_burst(p, base, 4, 1'b0, 4'ha);
    write_burst(p, base, 4, 1'b0, 4'hb, 1'b0, 0);
    read_burst(p, base, 4, 1'b0, 4'hc);
  endtask

  task automatic stress_case(input int p, input logic [7:0] base);
    int beats;
    repeat (4) begin
      beats = rand_len();
      write_burst(p, base, beats, 1'b0, 4'(take_bits(4)), 1'b0, 0);
      read_burst(p, base, beats, 1'b0, 4'(take_bits(4)));
    end
  endtask

  task automatic print_summary();
    $display("Errors: %0d value, %0d protocol", value_errors, proto_errors);
  endtask

  always @(posedge clk_i) begin
    if (arst_n_i) begin
      for (int p = 0; p < simmem_pkg::NUM_PORTS; p++) begin
        if (r_valid_o[p] && r_ready_i[p]) begin
          r_beats++;
          check_beat(0, p, 64'({r_id_o[p], r_last_o[p], r_data_o[p]}));
        end
        if (b_valid_o[p] && b_ready_i[p]) check_beat(1, p, 64'({b_id_o[p], b_resp_o[p]}));
        if (mon_w_valid_o[p]) begin
          check_beat(2, p, 64'({mon_w_addr_o[p], mon_w_data_o[p], mon_w_last_o[p]}));
        end
        if (mon_r_valid_o[p]) begin
          mon_r_pulses++;
          check_beat(3, p, 64'({mon_r_addr_o[p], mon_r_data_o[p], mon_r_last_o[p]}));
        end
      end
    end
  end

  // Master ready lines, random only during the back-pressure test
  initial begin
    r_ready_i = '1;
    b_ready_i = '1;
    forever begin
      @(posedge clk_i);
      #1;
      r_ready_i = bp_en ? 2'(take_bits(2)) : '1;
      b_ready_i = bp_en ? 2'(take_bits(2)) : '1;
    end
  end

  initial begin
    repeat (MAX_BEATS * simmem_pkg::NUM_PORTS * 20) @(posedge clk_i);
    proto_errors++;
    $display("Watchdog expired before all tests finished");
    print_summary();
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    arst_n_i   = 1'b0;
    aw_valid_i = '0;
    aw_addr_i  = '0;
    aw_len_i   = '0;
    aw_burst_i = '0;
    aw_id_i    = '0;
    w_valid_i  = '0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_last_i   = '0;
    ar_valid_i = '0;
    ar_addr_i  = '0;
    ar_len_i   = '0;
    ar_burst_i = '0;
    ar_id_i    = '0;
    repeat (5) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    test_name = "reset_state";
    @(posedge clk_i);
    assert ({r_valid_o, b_valid_o, mon_w_valid_o, mon_r_valid_o, w_ready_o} == '0) else begin
      proto_errors++;
      $display("A valid or W ready output is high right after reset");
    end
    // Idle ports accept addresses at once
    assert ((aw_ready_o & ar_ready_o) == '1) else begin
      proto_errors++;
      $display("AW or AR ready is low on an idle port after reset");
    end
    fork
      write_burst(0, 8'd0, 1, 1'b0, 4'h3, 1'b0, 0);
      write_burst(1, 8'd1, 1, 1'b0, 4'h5, 1'b0, 0);
    join
    fork
      read_burst(0, 8'd0, 1, 1'b0, 4'h3);
      read_burst(1, 8'd1, 1, 1'b0, 4'h5);
    join

    test_name = "incr_bursts";
    fork
      incr_case(0, 8'd16);
      incr_case(1, 8'd252);
    join

    test_name = "fixed_bursts";
    fork
      fixed_case(0, 8'd16);
      fixed_case(1, 8'd252);
    join

    // Each port reads what the other one wrote
    test_name = "shared_memory";
    fork
      write_burst(0, 8'd64, 8, 1'b0, 4'h1, 1'b0, 0);
      write_burst(1, 8'd96, 8, 1'b0, 4'h2, 1'b0, 0);
    join
    fork
      read_burst(0, 8'd96, 8, 1'b0, 4'h3);
      read_burst(1, 8'd64, 8, 1'b0, 4'h4);
    join

    test_name = "last_flag_errors";
    fork
      last_case(0, 8'd128, 1);
      last_case(1, 8'd160, 2);
    join

    test_name = "back_pressure";
    bp_en = 1'b1;
    fork
      stress_case(0, 8'd192);
      stress_case(1, 8'd224);
    join
    bp_en = 1'b0;

    repeat (4) @(posedge clk_i);
    for (int p = 0; p < simmem_pkg::NUM_PORTS; p++) begin
      for (int k = 0; k < 4; k++) begin
        assert (exp_q[k][p].size() == 0) else begin
          proto_errors++;
          $display("Port %0d is missing %0d expected %s", p, exp_q[k][p].size(), kind_names[k]);
        end
      end
    end
    assert (r_beats == mon_r_pulses) else begin
      proto_errors++;
      $display("Read monitor pulsed %0d times for %0d R transfers", mon_r_pulses, r_beats);
    end
    print_summary();
    if (value_errors == 0 && proto_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
